//--- common/nmcu_pkg.sv
`default_nettype none

package nmcu_pkg;

    // memory bus
    localparam int addr_width = 16;
    localparam int data_width = 32;

    // activation store, one tile side at most 15 words
    localparam int max_dim = 15;
    localparam int dim_width = 4;

    typedef logic [addr_width-1:0] addr_t;

    // activations are signed words
    typedef logic signed [data_width-1:0] data_word_t;

    // tile side or row/column index
    typedef logic [dim_width-1:0] dim_t;

endpackage

`default_nettype wire

//--- common/layer_pkg.sv
`default_nettype none

package layer_pkg;

    // conv still decodes but is skipped
    typedef enum logic [1:0] {
        kind_nop  = 2'd0,
        kind_conv = 2'd1,
        kind_maxp = 2'd2,
        kind_relu = 2'd3
    } layer_kind_t;

    localparam int max_descs = 8;

    typedef logic [$clog2(max_descs)-1:0] desc_idx_t;

    // descriptor word fields, bits 31:10 reserved
    localparam int kind_lsb = 0;
    localparam int width_lsb = 2;
    localparam int height_lsb = 6;

endpackage

`default_nettype wire

//--- common/layer_if.sv
`timescale 1ns/10ps
`default_nettype none

interface layer_if;
    import nmcu_pkg::*;
    import layer_pkg::*;

    // current descriptor and present tile size
    layer_kind_t kind;
    logic last;
    dim_t tile_w;
    dim_t tile_h;

    // table fill and layer sequencing
    logic desc_load;
    data_word_t desc_word;
    logic layer_step;
    logic run;
    logic busy;
    logic layer_done;

    // activation store port, read data one cycle late
    logic acc_we;
    dim_t acc_row;
    dim_t acc_col;
    data_word_t acc_wdata;
    data_word_t acc_rdata;

    modport decode (
        input desc_load, desc_word, layer_step,
        output kind, last, tile_w, tile_h
    );

    modport ctrl (
        input kind, last, tile_w, tile_h, busy, layer_done, acc_rdata,
        output desc_load, desc_word, layer_step, run,
        output acc_we, acc_row, acc_col, acc_wdata
    );

    modport exec (
        input kind, tile_w, tile_h, run, acc_we, acc_row, acc_col, acc_wdata,
        output busy, layer_done, acc_rdata
    );

endinterface

`default_nettype wire

//--- decode/desc_decode.sv
`timescale 1ns/10ps
`default_nettype none

module desc_decode (
    input wire clk,
    input wire rst,
    layer_if.decode lyr
);
    import nmcu_pkg::*;
    import layer_pkg::*;

    data_word_t desc_tab [max_descs];
    desc_idx_t wr_idx;
    desc_idx_t rd_idx;
    data_word_t cur;
    layer_kind_t load_kind;

    // filling covers the fetch phase, fill_end flags the final entry written
    logic filling;
    logic fill_end;

    assign cur = desc_tab[rd_idx];
    assign lyr.kind = layer_kind_t'(cur[kind_lsb +: $bits(layer_kind_t)]);
    assign load_kind = layer_kind_t'(lyr.desc_word[kind_lsb +: $bits(layer_kind_t)]);

    assign lyr.last = filling ? fill_end
                              : (lyr.kind == kind_nop) ||
                                (rd_idx == desc_idx_t'(max_descs - 1));

    always_ff @(posedge clk) begin
        if (lyr.desc_load) begin
            desc_tab[wr_idx] <= lyr.desc_word;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_idx <= '0;
            rd_idx <= '0;
            filling <= 1'b0;
            fill_end <= 1'b0;
            lyr.tile_w <= '0;
            lyr.tile_h <= '0;
        end else begin
            fill_end <= 1'b0;
            if (lyr.desc_load) begin
                wr_idx <= wr_idx + 1'b1;
                filling <= 1'b1;
                fill_end <= (load_kind == kind_nop) ||
                            (wr_idx == desc_idx_t'(max_descs - 1));
                // only entry zero carries the starting size
                if (wr_idx == '0) begin
                    lyr.tile_w <= lyr.desc_word[width_lsb +: dim_width];
                    lyr.tile_h <= lyr.desc_word[height_lsb +: dim_width];
                end
            end else if (fill_end) begin
                filling <= 1'b0;
            end

            if (lyr.layer_step) begin
                if (lyr.kind == kind_maxp) begin
                    lyr.tile_w <= lyr.tile_w >> 1;
                    lyr.tile_h <= lyr.tile_h >> 1;
                end
                // rewind for the next start
                if (lyr.last) begin
                    rd_idx <= '0;
                    wr_idx <= '0;
                end else begin
                    rd_idx <= rd_idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- execute/layer_exec.sv
`timescale 1ns/10ps
`default_nettype none

module layer_exec (
    input wire clk,
    input wire rst,
    layer_if.exec lyr
);
    import nmcu_pkg::*;
    import layer_pkg::*;

    // two banks, the active one holds the current layer input
    data_word_t bank [2][max_dim][max_dim];
    logic act;

    logic pool;
    dim_t out_w;
    dim_t out_h;
    dim_t row;
    dim_t col;
    logic [2:0] phase;
    data_word_t peak;
    data_word_t rd_q;

    dim_t rd_row;
    dim_t rd_col;
    dim_t wr_row;
    dim_t wr_col;
    logic wr_en;
    logic wr_bank;
    data_word_t wr_data;
    data_word_t eng_data;
    logic step_done;
    logic final_elem;

    assign pool = lyr.kind == kind_maxp;
    assign out_w = pool ? (lyr.tile_w >> 1) : lyr.tile_w;
    assign out_h = pool ? (lyr.tile_h >> 1) : lyr.tile_h;
    assign final_elem = (row == out_h - 1'b1) && (col == out_w - 1'b1);

    // relu writes on phase 1, max-pool after its fourth tap on phase 4
    assign step_done = lyr.busy && (pool ? (phase == 3'd4) : (phase == 3'd1));

    always_comb begin
        if (pool) begin
            eng_data = (rd_q > peak) ? rd_q : peak;
        end else begin
            eng_data = rd_q[data_width-1] ? '0 : rd_q;
        end
    end

    // taps of a 2x2 block, odd leftover rows and columns never read
    always_comb begin
        if (!lyr.busy) begin
            rd_row = lyr.acc_row;
            rd_col = lyr.acc_col;
        end else if (pool) begin
            rd_row = {row[dim_width-2:0], phase[1]};
            rd_col = {col[dim_width-2:0], phase[0]};
        end else begin
            rd_row = row;
            rd_col = col;
        end
    end

    // engine writes the idle bank, ctrl writes the active one
    assign wr_en = lyr.busy ? step_done : lyr.acc_we;
    assign wr_bank = lyr.busy ? ~act : act;
    assign wr_row = lyr.busy ? row : lyr.acc_row;
    assign wr_col = lyr.busy ? col : lyr.acc_col;
    assign wr_data = lyr.busy ? eng_data : lyr.acc_wdata;
    assign lyr.acc_rdata = rd_q;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            bank[wr_bank][wr_row][wr_col] <= wr_data;
        end
        rd_q <= bank[act][rd_row][rd_col];
        if (lyr.busy && pool) begin
            if (phase == 3'd1) begin
                peak <= rd_q;
            end else begin
                peak <= eng_data;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lyr.busy <= 1'b0;
            lyr.layer_done <= 1'b0;
            act <= 1'b0;
            row <= '0;
            col <= '0;
            phase <= '0;
        end else begin
            lyr.layer_done <= 1'b0;
            if (lyr.run) begin
                row <= '0;
                col <= '0;
                phase <= '0;
                // an empty result finishes at once
                if (out_w == '0 || out_h == '0) begin
                    lyr.layer_done <= 1'b1;
                    act <= ~act;
                end else begin
                    lyr.busy <= 1'b1;
                end
            end else if (step_done) begin
                phase <= '0;
                if (final_elem) begin
                    lyr.busy <= 1'b0;
                    lyr.layer_done <= 1'b1;
                    act <= ~act;
                end else if (col == out_w - 1'b1) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end else if (lyr.busy) begin
                phase <= phase + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/nmcu_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module nmcu_ctrl (
    input wire clk,
    input wire rst,
    input wire start,
    input wire nmcu_pkg::addr_t desc_addr,
    input wire nmcu_pkg::addr_t input_addr,
    input wire nmcu_pkg::addr_t output_addr,
    input wire nmcu_pkg::dim_t full_input_width,
    input wire nmcu_pkg::data_word_t mem_rdata,
    input wire ready,
    output logic done,
    output logic mem_sel,
    output logic mem_w,
    output nmcu_pkg::addr_t mem_addr,
    output nmcu_pkg::data_word_t mem_wdata,
    layer_if.ctrl lyr
);
    import nmcu_pkg::*;
    import layer_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_load,
        st_run,
        st_write,
        st_done
    } state_t;

    state_t state;
    dim_t row;
    dim_t col;
    addr_t addr_ptr;
    logic waiting;
    logic primed;
    logic final_wr;

    logic xfer_done;
    logic tile_empty;
    logic row_end;
    logic tile_end;
    logic runnable;

    assign xfer_done = mem_sel && ready;
    assign tile_empty = (lyr.tile_w == '0) || (lyr.tile_h == '0);
    assign row_end = col == lyr.tile_w - 1'b1;
    assign tile_end = row_end && (row == lyr.tile_h - 1'b1);
    assign runnable = (lyr.kind == kind_maxp) || (lyr.kind == kind_relu);

    // fetched words go straight from the bus into table and store
    assign lyr.desc_load = (state == st_fetch) && xfer_done;
    assign lyr.desc_word = mem_rdata;
    assign lyr.acc_we = (state == st_load) && xfer_done;
    assign lyr.acc_row = row;
    assign lyr.acc_col = col;
    assign lyr.acc_wdata = mem_rdata;

    // nop and conv entries are stepped over without running
    assign lyr.run = (state == st_run) && !waiting && !lyr.busy && runnable;
    assign lyr.layer_step = (state == st_run) &&
                            (waiting ? lyr.layer_done : (!lyr.busy && !runnable));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            done <= 1'b0;
            mem_sel <= 1'b0;
            mem_w <= 1'b0;
            mem_addr <= '0;
            mem_wdata <= '0;
            row <= '0;
            col <= '0;
            addr_ptr <= '0;
            waiting <= 1'b0;
            primed <= 1'b0;
            final_wr <= 1'b0;
        end else if (mem_sel) begin
            // request held until ready, then one cycle with select low
            if (ready) begin
                mem_sel <= 1'b0;
                mem_w <= 1'b0;
                if (state == st_load) begin
                    if (tile_end) begin
                        state <= st_run;
                    end else if (row_end) begin
                        col <= '0;
                        row <= row + 1'b1;
                        addr_ptr <= addr_ptr + addr_t'(full_input_width);
                    end else begin
                        col <= col + 1'b1;
                    end
                end else if (state == st_write && final_wr) begin
                    state <= st_done;
                    done <= 1'b1;
                end
            end
        end else begin
            case (state)
                st_idle, st_done: begin
                    if (start) begin
                        state <= st_fetch;
                        done <= 1'b0;
                        mem_sel <= 1'b1;
                        mem_addr <= desc_addr;
                    end
                end

                st_fetch: begin
                    if (lyr.last) begin
                        state <= st_load;
                        row <= '0;
                        col <= '0;
                        addr_ptr <= input_addr;
                    end else begin
                        mem_sel <= 1'b1;
                        mem_addr <= mem_addr + 1'b1;
                    end
                end

                // addr_ptr holds the start of the current input row
                st_load: begin
                    if (tile_empty) begin
                        state <= st_run;
                    end else begin
                        mem_sel <= 1'b1;
                        mem_addr <= addr_ptr + addr_t'(col);
                    end
                end

                st_run: begin
                    if (lyr.run) begin
                        waiting <= 1'b1;
                    end
                    if (lyr.layer_step) begin
                        waiting <= 1'b0;
                        if (lyr.last) begin
                            state <= st_write;
                            row <= '0;
                            col <= '0;
                            primed <= 1'b0;
                            addr_ptr <= output_addr;
                        end
                    end
                end

                // store is read one word ahead of the bus write
                st_write: begin
                    if (!primed) begin
                        if (tile_empty) begin
                            state <= st_done;
                            done <= 1'b1;
                        end else begin
                            primed <= 1'b1;
                        end
                    end else begin
                        mem_sel <= 1'b1;
                        mem_w <= 1'b1;
                        mem_wdata <= lyr.acc_rdata;
                        mem_addr <= addr_ptr;
                        addr_ptr <= addr_ptr + 1'b1;
                        final_wr <= tile_end;
                        if (row_end && !tile_end) begin
                            col <= '0;
                            row <= row + 1'b1;
                        end else if (!row_end) begin
                            col <= col + 1'b1;
                        end
                    end
                end

                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/nmcu_top.sv
`timescale 1ns/10ps
`default_nettype none

module nmcu_top (
    input wire clk,
    input wire rst,

    input wire start,
    input wire nmcu_pkg::addr_t desc_addr,
    input wire nmcu_pkg::addr_t input_addr,
    input wire nmcu_pkg::addr_t output_addr,
    input wire nmcu_pkg::dim_t full_input_width,
    output wire done,

    // memory bus
    output wire mem_sel,
    output wire mem_w,
    output wire nmcu_pkg::addr_t mem_addr,
    output wire nmcu_pkg::data_word_t mem_wdata,
    input wire nmcu_pkg::data_word_t mem_rdata,
    input wire ready
);

    layer_if lyr ();

    nmcu_ctrl u_ctrl (
        .clk(clk),
        .rst(rst),
        .start(start),
        .desc_addr(desc_addr),
        .input_addr(input_addr),
        .output_addr(output_addr),
        .full_input_width(full_input_width),
        .mem_rdata(mem_rdata),
        .ready(ready),
        .done(done),
        .mem_sel(mem_sel),
        .mem_w(mem_w),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .lyr(lyr.ctrl)
    );

    desc_decode u_decode (
        .clk(clk),
        .rst(rst),
        .lyr(lyr.decode)
    );

    layer_exec u_exec (
        .clk(clk),
        .rst(rst),
        .lyr(lyr.exec)
    );

endmodule

`default_nettype wire

//--- bench/nmcu_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module nmcu_assertions (
    input wire clk,
    input wire rst,
    input wire mem_sel,
    input wire mem_w,
    input wire nmcu_pkg::addr_t mem_addr,
    input wire ready,
    input wire done
);

    // number of failed assertions so far
    int fail_count = 0;

    // a waiting request keeps its address and direction
    property hold_while_waiting;
        @(posedge clk) disable iff (rst)
            mem_sel && !ready |=> mem_sel && $stable(mem_addr) && $stable(mem_w);
    endproperty

    property idle_after_transfer;
        @(posedge clk) disable iff (rst)
            mem_sel && ready |=> !mem_sel;
    endproperty

    property write_needs_select;
        @(posedge clk) disable iff (rst)
            mem_w |-> mem_sel;
    endproperty

    property done_bus_quiet;
        @(posedge clk) disable iff (rst)
            done |-> !mem_sel;
    endproperty

    assert property (hold_while_waiting) else begin
        $error("memory request changed while waiting");
        fail_count++;
    end

    assert property (idle_after_transfer) else begin
        $error("select high right after a transfer");
        fail_count++;
    end

    assert property (write_needs_select) else begin
        $error("write flag high without select");
        fail_count++;
    end

    assert property (done_bus_quiet) else begin
        $error("select high while done is set");
        fail_count++;
    end

endmodule

bind nmcu_top nmcu_assertions u_assertions (
    .clk(clk),
    .rst(rst),
    .mem_sel(mem_sel),
    .mem_w(mem_w),
    .mem_addr(mem_addr),
    .ready(ready),
    .done(done)
);

`default_nettype wire

//--- bench/tb_nmcu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_nmcu;
    import nmcu_pkg::*;

    localparam int max_tests = 8;

    logic clk;
    logic rst;
    logic start;
    addr_t desc_addr;
    addr_t input_addr;
    addr_t output_addr;
    dim_t full_input_width;
    data_word_t mem_rdata;
    logic ready;
    logic done;
    logic mem_sel;
    logic mem_w;
    addr_t mem_addr;
    data_word_t mem_wdata;

    // memory model contents
    data_word_t mem [0:65535];

    // trace contents per test
    addr_t test_desc [max_tests];
    addr_t test_in [max_tests];
    addr_t test_out [max_tests];
    dim_t test_fw [max_tests];
    int n_tests;
    addr_t img_addr [$];
    data_word_t img_data [$];
    int img_test [$];
    data_word_t out_word [$];
    int out_test [$];

    // transfers still due in the running test
    addr_t exp_addr [$];
    logic exp_we [$];
    data_word_t exp_data [$];

    int cycles = 0;
    int cycle_limit = 0;

    nmcu_top UUT (
        .clk(clk),
        .rst(rst),
        .start(start),
        .desc_addr(desc_addr),
        .input_addr(input_addr),
        .output_addr(output_addr),
        .full_input_width(full_input_width),
        .done(done),
        .mem_sel(mem_sel),
        .mem_w(mem_w),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .ready(ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            report_problem("run did not finish within its cycle limit");
        end
        if (UUT.u_assertions.fail_count != 0) begin
            report_problem("a memory bus assertion failed");
        end
    end

    // memory model with 0 to 3 wait cycles before ready
    initial begin
        int wait_left;
        logic in_req;
        int seed;
        seed = 32'hafd55955;
        void'($urandom(seed));
        ready = 1'b0;
        mem_rdata = '0;
        in_req = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            if (ready) begin
                ready <= 1'b0;
                if (mem_sel) begin
                    complete_transfer();
                end
            end else if (mem_sel) begin
                if (!in_req) begin
                    in_req = 1'b1;
                    wait_left = $urandom % 4;
                end
                if (wait_left == 0) begin
                    in_req = 1'b0;
                    ready <= 1'b1;
                    mem_rdata <= mem[mem_addr];
                end else begin
                    wait_left--;
                end
            end
        end
    end

    task automatic stop_failed();
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic report_problem(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        stop_failed();
    endtask

    task automatic check_word(input string name, input data_word_t got, input data_word_t want);
        if (got !== want) begin
            $display("Fail at time %0t: %s = %h, expected %h", $time, name, got, want);
            stop_failed();
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t want);
        if (got !== want) begin
            $display("Fail at time %0t: %s = %h, expected %h", $time, name, got, want);
            stop_failed();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("Fail at time %0t: %s = %b, expected %b", $time, name, got, want);
            stop_failed();
        end
    endtask

    // called on the edge that completes a transfer
    task automatic complete_transfer();
        addr_t want_addr;
        logic want_we;
        data_word_t want_data;
        if (exp_addr.size() == 0) begin
            report_problem("memory transfer seen where none was expected");
        end else begin
            want_addr = exp_addr.pop_front();
            want_we = exp_we.pop_front();
            want_data = exp_data.pop_front();
            check_flag("mem_w", mem_w, want_we);
            check_addr("mem_addr", mem_addr, want_addr);
            if (want_we) begin
                check_word("mem_wdata", mem_wdata, want_data);
            end
        end
    endtask

    task automatic read_trace();
        int fd;
        int code;
        int n;
        int i;
        logic [63:0] tok;
        logic [8*200-1:0] rest;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] v;
        n_tests = 0;
        fd = $fopen("bench/nmcu_trace.txt", "r");
        if (fd == 0) begin
            report_problem("trace file bench/nmcu_trace.txt could not be opened");
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    code = $fgets(rest, fd);
                end else if (tok == "test") begin
                    if (n_tests == max_tests) begin
                        report_problem("trace holds more tests than the bench can keep");
                    end
                    code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                    test_desc[n_tests] = a[15:0];
                    test_in[n_tests] = b[15:0];
                    test_out[n_tests] = c[15:0];
                    test_fw[n_tests] = d[3:0];
                end else if (tok == "mem") begin
                    code = $fscanf(fd, "%h %d", a, n);
                    for (i = 0; i < n; i++) begin
                        code = $fscanf(fd, "%h", v);
                        img_addr.push_back(addr_t'(a + i));
                        img_data.push_back(v);
                        img_test.push_back(n_tests);
                    end
                end else if (tok == "exp") begin
                    code = $fscanf(fd, "%d", n);
                    for (i = 0; i < n; i++) begin
                        code = $fscanf(fd, "%h", v);
                        out_word.push_back(v);
                        out_test.push_back(n_tests);
                    end
                end else if (tok == "end") begin
                    n_tests++;
                end else begin
                    report_problem("unknown keyword in trace file");
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic clear_expected();
        exp_addr.delete();
        exp_we.delete();
        exp_data.delete();
    endtask

    task automatic push_expected(input addr_t a, input logic we, input data_word_t d);
        exp_addr.push_back(a);
        exp_we.push_back(we);
        exp_data.push_back(d);
    endtask

    // loads the test image and lists the bus transfers it must produce
    task automatic build_expected(input int t);
        int i;
        int r;
        int c;
        int k;
        int n_desc;
        int w;
        int h;
        data_word_t d;
        clear_expected();
        for (i = 0; i < img_addr.size(); i++) begin
            if (img_test[i] == t) begin
                mem[img_addr[i]] = img_data[i];
            end
        end
        // kind in bits 1:0, width 5:2, height 9:6
        d = mem[test_desc[t]];
        w = d[5:2];
        h = d[9:6];
        n_desc = 0;
        do begin
            d = mem[addr_t'(test_desc[t] + n_desc)];
            push_expected(addr_t'(test_desc[t] + n_desc), 1'b0, '0);
            n_desc++;
        end while (d[1:0] != 2'd0 && n_desc < 8);
        for (r = 0; r < h; r++) begin
            for (c = 0; c < w; c++) begin
                push_expected(addr_t'(test_in[t] + r * test_fw[t] + c), 1'b0, '0);
            end
        end
        k = 0;
        for (i = 0; i < out_word.size(); i++) begin
            if (out_test[i] == t) begin
                push_expected(addr_t'(test_out[t] + k), 1'b1, out_word[i]);
                k++;
            end
        end
    endtask

    task automatic run_test(input int t);
        build_expected(t);
        @(posedge clk);
        desc_addr <= test_desc[t];
        input_addr <= test_in[t];
        output_addr <= test_out[t];
        full_input_width <= test_fw[t];
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        while (!done) begin
            @(posedge clk);
        end
        if (exp_addr.size() != 0) begin
            report_problem("done rose before every expected transfer was seen");
        end
        check_flag("mem_sel", mem_sel, 1'b0);
    endtask

    initial begin
        int t;
        int total;
        rst = 1'b1;
        start = 1'b0;
        desc_addr = '0;
        input_addr = '0;
        output_addr = '0;
        full_input_width = '0;
        read_trace();
        total = 0;
        for (t = 0; t < n_tests; t++) begin
            build_expected(t);
            total += exp_addr.size();
        end
        clear_expected();
        cycle_limit = 8 * total + 200 * n_tests + 10;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_flag("mem_sel", mem_sel, 1'b0);
        check_flag("mem_w", mem_w, 1'b0);
        check_flag("done", done, 1'b0);
        for (t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        @(posedge clk);
        if (UUT.u_assertions.fail_count != 0) begin
            report_problem("a memory bus assertion failed");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- bench/nmcu_trace.txt
# test: desc_addr input_addr output_addr full_input_width, all hex
# mem: addr count words stored from addr up; exp: count words written in order; end closes a test
test 0100 0200 0300 5
mem 0100 2 0000008f 00000000
mem 0200 5 00000005 fffffffd 00000000 aaaaaaaa bbbbbbbb
mem 0205 3 ffffffff 7fffffff 80000000
exp 6 00000005 00000000 00000000 00000000 7fffffff 00000000
end
test 0400 0500 0600 7
mem 0400 2 0000015e 00000000
mem 0500 7 00000001 fffffffe 00000003 00000004 fffffffb fffffffa 00000009
mem 0507 7 fffffff9 00000000 00000002 ffffffff fffffffd fffffffc 00000008
mem 050e 7 fffffff6 ffffffec 00000006 00000005 00000064 ffffff9c 00000001
mem 0515 7 ffffffe2 fffffff1 00000007 00000007 ffffffff 00000032 00000002
mem 051c 7 0000000b 0000000c 0000000d 0000000e 0000000f 00000010 00000011
exp 6 00000001 00000004 fffffffd fffffff6 00000007 00000064
end
test 0700 0800 0900 6
mem 0700 3 00000112 00000003 00000000
mem 0800 4 ffffffff fffffffe 00000003 fffffffc
mem 0806 4 fffffffb fffffffa fffffff9 00000002
mem 080c 4 00000008 fffffff7 fffffff6 fffffff5
mem 0812 4 00000000 00000001 fffffff4 fffffff3
exp 4 00000000 00000003 00000008 00000000
end
test 0a00 0b00 0c00 3
mem 0a00 1 0000008c
mem 0b00 6 80000000 ffffffff 12345678 00000000 7fffffff deadbeef
exp 6 80000000 ffffffff 12345678 00000000 7fffffff deadbeef
end
test 0d00 0e00 0f00 4
mem 0d00 8 00000092 00000003 00000003 00000003 00000003 00000003 00000003 00000003
mem 0e00 8 fffffff8 fffffffd 00000014 ffffffff fffffffc fffffff7 00000005 00000006
exp 2 00000000 00000014
end

//--- nmcu_top.f
common/nmcu_pkg.sv
common/layer_pkg.sv
common/layer_if.sv
decode/desc_decode.sv
execute/layer_exec.sv
hdl/nmcu_ctrl.sv
hdl/nmcu_top.sv
bench/nmcu_assertions.sv
bench/tb_nmcu.sv

//--- Bender.yml
package:
  name: nmcu

sources:
  - common/nmcu_pkg.sv
  - common/layer_pkg.sv
  - common/layer_if.sv
  - decode/desc_decode.sv
  - execute/layer_exec.sv
  - hdl/nmcu_ctrl.sv
  - hdl/nmcu_top.sv
  - target: test
    files:
      - bench/nmcu_assertions.sv
      - bench/tb_nmcu.sv
